/* verilog.f */
logic/cache_geometry_pkg.sv
logic/cache_bus_pkg.sv
logic/sp_ram.sv
logic/victim_select.sv
logic/dcache.sv
logic/line_memory.sv
logic/dcache_subsystem.sv
verification/dcache_tb.sv

/* verification/dcache_tb.sv */
`timescale 1ns/1ns

module dcache_tb;

	localparam logic [31:0] CACHEABLE_LIMIT = 32'h0000_c000;
	localparam int RESET_CYCLES = 16;
	// 4 + 3 + 14 + 12 + 4 + 300 accesses over the six tests
	localparam int NUM_REQUESTS = 337;
	// Store miss plus request and idle cycles, rounded up
	localparam int WORST_CYCLES = 16;
	localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_REQUESTS * WORST_CYCLES * 2) * 20;
	localparam int SHADOW_WORDS = 8192;

	logic clk;
	logic rst;
	logic req_valid;
	cache_bus_pkg::cpu_req_t req;
	logic resp_valid;
	cache_bus_pkg::cpu_resp_t resp;

	int errors;
	int ptr;
	logic last_hit;
	int unsigned seed_value;
	logic [63:0] shadow [SHADOW_WORDS];
	logic model_valid [cache_geometry_pkg::NUM_SETS][4];
	cache_geometry_pkg::tag_t model_tag [cache_geometry_pkg::NUM_SETS][4];

	dcache_subsystem #(
		.CACHEABLE_LIMIT(CACHEABLE_LIMIT),
		.MEM_LINES      (4096),
		.MEM_LATENCY    (3)
	) dcache_subsystem_inst (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.resp_valid(resp_valid),
		.resp      (resp)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			errors++;
			$display("error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	function automatic logic [63:0] apply_strobes(logic [63:0] old, logic [63:0] wdata,
			logic [7:0] strb);
		logic [63:0] result;
		result = old;
		for (int b = 0; b < 8; b++) begin
			if (strb[b]) begin
				result[8*b +: 8] = wdata[8*b +: 8];
			end
		end
		return result;
	endfunction

	// Free way first, otherwise the shared rotating pointer
	task automatic predict_hit(input logic [31:0] addr, output logic hit);
		int set;
		int way;
		cache_geometry_pkg::tag_t tag;
		set = addr[9:4];
		tag = addr[31:10];
		way = -1;
		hit = 1'b0;
		if (addr >= CACHEABLE_LIMIT) begin
			return;
		end
		for (int w = 0; w < 4; w++) begin
			if (model_valid[set][w] && model_tag[set][w] == tag) begin
				hit = 1'b1;
			end
		end
		if (hit) begin
			return;
		end
		for (int w = 3; w >= 0; w--) begin
			if (!model_valid[set][w]) begin
				way = w;
			end
		end
		if (way < 0) begin
			way = ptr;
			ptr = (ptr + 1) % 4;
		end
		model_valid[set][way] = 1'b1;
		model_tag[set][way] = tag;
	endtask

	task automatic do_access(input logic [31:0] addr, input logic write, input logic [63:0] wdata,
			input logic [7:0] strb, output logic [63:0] rdata, output logic hit, output int lat);
		@(posedge clk);
		req_valid <= 1'b1;
		req <= '{addr: addr, write: write, wdata: wdata, strb: strb};
		@(posedge clk);
		req_valid <= 1'b0;
		lat = 0;
		// Sampled mid-cycle, counted from the cycle the request was taken
		do begin
			@(negedge clk);
			lat++;
		end while (!resp_valid);
		rdata = resp.rdata;
		hit = resp.hit;
	endtask

	task automatic verify_access(input logic [31:0] addr, input logic write,
			input logic [63:0] wdata, input logic [7:0] strb);
		logic [63:0] exp_data;
		logic [63:0] rdata;
		logic exp_hit;
		int lat;
		exp_data = apply_strobes(shadow[addr[15:3]], wdata, write ? strb : 8'h00);
		shadow[addr[15:3]] = exp_data;
		predict_hit(addr, exp_hit);
		do_access(addr, write, wdata, strb, rdata, last_hit, lat);
		check(rdata, exp_data, $sformatf("rdata at %h", addr));
		check(last_hit, exp_hit, $sformatf("hit at %h", addr));
		if (exp_hit && !write) begin
			check(lat, 2, $sformatf("load hit latency at %h", addr));
		end
	endtask

	task automatic test_cold_load();
		verify_access(32'h0000_0000, 1'b0, '0, '0);
		verify_access(32'h0000_1238, 1'b0, '0, '0);
		verify_access(32'h0000_5a58, 1'b0, '0, '0);
		verify_access(32'h0000_bff8, 1'b0, '0, '0);
	endtask

	task automatic test_load_hit();
		verify_access(32'h0000_2340, 1'b0, '0, '0);
		verify_access(32'h0000_2340, 1'b0, '0, '0);
		check(last_hit, 1'b1, "repeated load hit");
		verify_access(32'h0000_2348, 1'b0, '0, '0);
		check(last_hit, 1'b1, "other word hit");
	endtask

	// Both stored lines share set 7 with the seven evicting tags
	task automatic test_store();
		verify_access(32'h0000_0070, 1'b0, '0, '0);
		verify_access(32'h0000_0070, 1'b1, 64'h1122_3344_5566_7788, 8'h0f);
		verify_access(32'h0000_0070, 1'b0, '0, '0);
		verify_access(32'h0000_0478, 1'b1, 64'hdead_beef_cafe_f00d, 8'hc3);
		verify_access(32'h0000_0478, 1'b0, '0, '0);
		for (int k = 0; k < 7; k++) begin
			verify_access(32'h0000_0870 + k * 32'h400, 1'b0, '0, '0);
		end
		verify_access(32'h0000_0070, 1'b0, '0, '0);
		check(last_hit, 1'b0, "reload of evicted store line");
		verify_access(32'h0000_0478, 1'b0, '0, '0);
		check(last_hit, 1'b0, "reload of evicted store-miss line");
	endtask

	// Re-reads run newest first, so survivors hit and evicted tags miss
	task automatic test_replacement();
		for (int k = 0; k < 6; k++) begin
			verify_access(32'h0000_3150 + k * 32'h400, 1'b0, '0, '0);
		end
		for (int k = 0; k < 6; k++) begin
			verify_access(32'h0000_3158 + (5 - k) * 32'h400, 1'b0, '0, '0);
		end
	endtask

	task automatic test_uncached();
		verify_access(32'h0000_c010, 1'b0, '0, '0);
		verify_access(32'h0000_c010, 1'b0, '0, '0);
		check(last_hit, 1'b0, "uncached load hit");
		verify_access(32'h0000_d128, 1'b1, 64'h0123_4567_89ab_cdef, 8'hff);
		verify_access(32'h0000_d128, 1'b0, '0, '0);
	endtask

	// Two sets, sixteen 1 KB blocks, the top four blocks uncached
	task automatic test_random();
		logic [31:0] addr;
		logic write;
		logic [63:0] wdata;
		logic [7:0] strb;
		for (int i = 0; i < 300; i++) begin
			addr = 32'h0000_9000 + ($urandom % 16) * 32'h400 + (32'h90 + ($urandom % 2) * 32'h10)
				+ ($urandom % 2) * 8;
			write = $urandom % 2;
			wdata = {$urandom, $urandom};
			strb = $urandom % 256;
			verify_access(addr, write, wdata, strb);
		end
	endtask

	initial begin
		logic [31:0] a;
		seed_value = $urandom(32'hbc69);
		errors = 0;
		ptr = 0;
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		for (int i = 0; i < SHADOW_WORDS; i++) begin
			a = i * 8;
			shadow[i] = {~a, a};
		end
		for (int s = 0; s < cache_geometry_pkg::NUM_SETS; s++) begin
			for (int w = 0; w < 4; w++) begin
				model_valid[s][w] = 1'b0;
				model_tag[s][w] = '0;
			end
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check(resp_valid, 1'b0, "resp_valid after reset");
		test_cold_load();
		test_load_hit();
		test_store();
		test_replacement();
		test_uncached();
		test_random();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: the run timed out after %0d ns without finishing", WATCHDOG_NS);
		$display("test failed");
		$finish;
	end

endmodule

/* logic/dcache_subsystem.sv */
`timescale 1ns/1ns

module dcache_subsystem #(
	parameter logic [cache_geometry_pkg::ADDR_W-1:0] CACHEABLE_LIMIT = 32'h0000_c000,
	parameter int MEM_LINES = 4096,
	parameter int MEM_LATENCY = 3
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     req_valid,
	input  cache_bus_pkg::cpu_req_t  req,
	output logic                     resp_valid,
	output cache_bus_pkg::cpu_resp_t resp
);

	logic mem_req_valid;
	logic mem_resp_valid;
	cache_bus_pkg::mem_req_t mem_req;
	cache_bus_pkg::mem_resp_t mem_resp;

	dcache #(
		.CACHEABLE_LIMIT(CACHEABLE_LIMIT)
	) dcache_inst (
		.clk           (clk),
		.rst           (rst),
		.req_valid     (req_valid),
		.req           (req),
		.resp_valid    (resp_valid),
		.resp          (resp),
		.mem_req_valid (mem_req_valid),
		.mem_req       (mem_req),
		.mem_resp_valid(mem_resp_valid),
		.mem_resp      (mem_resp)
	);

	line_memory #(
		.MEM_LINES  (MEM_LINES),
		.MEM_LATENCY(MEM_LATENCY)
	) line_memory_inst (
		.clk           (clk),
		.rst           (rst),
		.mem_req_valid (mem_req_valid),
		.mem_req       (mem_req),
		.mem_resp_valid(mem_resp_valid),
		.mem_resp      (mem_resp)
	);

endmodule

/* logic/line_memory.sv */
`timescale 1ns/1ns

module line_memory #(
	parameter int MEM_LINES = 4096,
	parameter int MEM_LATENCY = 3
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     mem_req_valid,
	input  cache_bus_pkg::mem_req_t  mem_req,
	output logic                     mem_resp_valid,
	output cache_bus_pkg::mem_resp_t mem_resp
);

	localparam int IDX_W = $clog2(MEM_LINES);

	cache_geometry_pkg::line_t mem [MEM_LINES];
	cache_geometry_pkg::line_t line_sr [MEM_LATENCY];
	logic [MEM_LATENCY-1:0] valid_sr;
	logic [IDX_W-1:0] idx;

	// Each word holds its own byte address, inverted in the upper half
	function automatic cache_geometry_pkg::line_t init_line(int unsigned n);
		logic [cache_geometry_pkg::ADDR_W-1:0] base;
		logic [cache_geometry_pkg::ADDR_W-1:0] upper;
		cache_geometry_pkg::line_t l;
		base = n * cache_geometry_pkg::LINE_BYTES;
		upper = base + 8;
		l.lo = {~base, base};
		l.hi = {~upper, upper};
		return l;
	endfunction

	// Line addresses wrap at the memory depth
	assign idx = mem_req.line_addr[IDX_W-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MEM_LINES; i++) begin
				mem[i] <= init_line(i);
			end
		end else if (mem_req_valid && mem_req.write) begin
			mem[idx] <= mem_req.line;
		end
	end

	// Latency pipe, the read sees contents before a same-cycle write
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_sr <= '0;
		end else begin
			valid_sr <= (valid_sr << 1) | MEM_LATENCY'(mem_req_valid);
		end
	end

	always_ff @(posedge clk) begin
		if (mem_req_valid) begin
			line_sr[0] <= mem[idx];
		end
		for (int s = 1; s < MEM_LATENCY; s++) begin
			line_sr[s] <= line_sr[s-1];
		end
	end

	assign mem_resp_valid = valid_sr[MEM_LATENCY-1];
	assign mem_resp.line = line_sr[MEM_LATENCY-1];

	single_outstanding_a: assert property (
		@(posedge clk) disable iff (rst)
		mem_req_valid |-> !(|valid_sr)
	) else $error("line_memory: request while another is outstanding");

endmodule

/* logic/dcache.sv */
`timescale 1ns/1ns

module dcache #(
	parameter logic [cache_geometry_pkg::ADDR_W-1:0] CACHEABLE_LIMIT = 32'h0000_c000
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     req_valid,
	input  cache_bus_pkg::cpu_req_t  req,
	output logic                     resp_valid,
	output cache_bus_pkg::cpu_resp_t resp,
	output logic                     mem_req_valid,
	output cache_bus_pkg::mem_req_t  mem_req,
	input  logic                     mem_resp_valid,
	input  cache_bus_pkg::mem_resp_t mem_resp
);

	localparam int WAYS = cache_geometry_pkg::NUM_WAYS;
	localparam int OFF = cache_geometry_pkg::OFFSET_W;
	localparam int IDX = cache_geometry_pkg::INDEX_W;
	localparam int AW = cache_geometry_pkg::ADDR_W;

	typedef enum logic [2:0] {S_IDLE, S_LOOKUP, S_MEM_READ, S_MEM_WRITE, S_RESPOND} state_t;

	state_t state;
	cache_bus_pkg::cpu_req_t req_q;
	logic uncached_q;
	logic hit_q;
	logic full_q;
	cache_geometry_pkg::way_mask_t way_q;
	cache_geometry_pkg::line_t line_q;

	cache_geometry_pkg::tag_entry_t tag_rd [WAYS];
	cache_geometry_pkg::line_t line_rd [WAYS];
	cache_geometry_pkg::tag_entry_t tag_wr;
	cache_geometry_pkg::tag_t req_tag;
	cache_geometry_pkg::index_t ram_addr;
	cache_geometry_pkg::way_mask_t hit_mask;
	cache_geometry_pkg::way_mask_t valid_bits;
	cache_geometry_pkg::way_mask_t victim;
	cache_geometry_pkg::line_t hit_line;
	cache_geometry_pkg::line_t merged_hit;
	cache_geometry_pkg::line_t merged_fill;
	logic req_cacheable;
	logic lookup_hit;
	logic ram_rd_en;
	logic fill_we;

	// Byte-merge of store data into the addressed word; loads pass through
	function automatic cache_geometry_pkg::line_t merge_store(
		cache_geometry_pkg::line_t src, cache_bus_pkg::cpu_req_t r);
		logic [cache_geometry_pkg::WORD_W-1:0] word;
		cache_geometry_pkg::line_t merged;
		merged = src;
		word = r.addr[cache_geometry_pkg::WORD_SEL] ? src.hi : src.lo;
		if (r.write) begin
			for (int b = 0; b < cache_geometry_pkg::WORD_W / 8; b++) begin
				if (r.strb[b]) begin
					word[8*b +: 8] = r.wdata[8*b +: 8];
				end
			end
		end
		if (r.addr[cache_geometry_pkg::WORD_SEL]) begin
			merged.hi = word;
		end else begin
			merged.lo = word;
		end
		return merged;
	endfunction

	assign req_cacheable = req.addr < CACHEABLE_LIMIT;
	assign req_tag = req_q.addr[AW-1 -: cache_geometry_pkg::TAG_W];
	assign ram_addr = (state == S_IDLE) ? req.addr[OFF +: IDX] : req_q.addr[OFF +: IDX];
	assign ram_rd_en = (state == S_IDLE) && req_valid && req_cacheable;
	// Misses and stores land in the way during the response cycle
	assign fill_we = (state == S_RESPOND) && !uncached_q && (req_q.write || !hit_q);
	assign tag_wr = '{valid: 1'b1, tag: req_tag};

	always_comb begin
		hit_mask = '0;
		valid_bits = '0;
		hit_line = '0;
		for (int w = 0; w < WAYS; w++) begin
			valid_bits[w] = tag_rd[w].valid;
			hit_mask[w] = tag_rd[w].valid && (tag_rd[w].tag == req_tag);
			if (hit_mask[w]) begin
				hit_line = hit_line | line_rd[w];
			end
		end
	end

	assign lookup_hit = |hit_mask;
	assign merged_hit = merge_store(hit_line, req_q);
	assign merged_fill = merge_store(mem_resp.line, req_q);

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		sp_ram #(
			.payload_t(cache_geometry_pkg::tag_entry_t),
			.DEPTH    (cache_geometry_pkg::NUM_SETS)
		) tag_ram (
			.clk  (clk),
			.rst  (rst),
			.en   (ram_rd_en || (fill_we && way_q[w])),
			.we   (fill_we && way_q[w]),
			.addr (ram_addr),
			.wdata(tag_wr),
			.rdata(tag_rd[w])
		);

		sp_ram #(
			.payload_t(cache_geometry_pkg::line_t),
			.DEPTH    (cache_geometry_pkg::NUM_SETS)
		) data_ram (
			.clk  (clk),
			.rst  (rst),
			.en   (ram_rd_en || (fill_we && way_q[w])),
			.we   (fill_we && way_q[w]),
			.addr (ram_addr),
			.wdata(line_q),
			.rdata(line_rd[w])
		);
	end

	victim_select victim_select_inst (
		.clk       (clk),
		.rst       (rst),
		.valid_bits(valid_bits),
		.advance   (fill_we && !hit_q && full_q),
		.victim    (victim)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			mem_req_valid <= 1'b0;
		end else begin
			mem_req_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					if (req_valid && req_cacheable) begin
						state <= S_LOOKUP;
					end else if (req_valid) begin
						state <= S_MEM_READ;
						mem_req_valid <= 1'b1;
					end
				end
				S_LOOKUP: begin
					if (!lookup_hit) begin
						state <= S_MEM_READ;
						mem_req_valid <= 1'b1;
					end else if (req_q.write) begin
						state <= S_MEM_WRITE;
						mem_req_valid <= 1'b1;
					end else begin
						state <= S_RESPOND;
					end
				end
				S_MEM_READ: begin
					if (mem_resp_valid && req_q.write) begin
						state <= S_MEM_WRITE;
						mem_req_valid <= 1'b1;
					end else if (mem_resp_valid) begin
						state <= S_RESPOND;
					end
				end
				S_MEM_WRITE: begin
					if (mem_resp_valid) begin
						state <= S_RESPOND;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			S_IDLE: begin
				if (req_valid) begin
					req_q <= req;
					uncached_q <= !req_cacheable;
					hit_q <= 1'b0;
					mem_req <= '{line_addr: req.addr[AW-1:OFF], write: 1'b0, line: '0};
				end
			end
			S_LOOKUP: begin
				hit_q <= lookup_hit;
				way_q <= lookup_hit ? hit_mask : victim;
				full_q <= &valid_bits;
				line_q <= merged_hit;
				// Only a store hit goes straight to a memory write
				mem_req.write <= lookup_hit;
				mem_req.line <= merged_hit;
			end
			S_MEM_READ: begin
				if (mem_resp_valid) begin
					line_q <= merged_fill;
					mem_req.write <= 1'b1;
					mem_req.line <= merged_fill;
				end
			end
			default: ;
		endcase
	end

	assign resp_valid = (state == S_RESPOND);
	assign resp.rdata = req_q.addr[cache_geometry_pkg::WORD_SEL] ? line_q.hi : line_q.lo;
	assign resp.hit = hit_q;

	hit_onehot_a: assert property (
		@(posedge clk) disable iff (rst)
		(state == S_LOOKUP) |-> $onehot0(hit_mask)
	) else $error("dcache: line present in more than one way");

	req_when_idle_a: assert property (
		@(posedge clk) disable iff (rst)
		req_valid |-> (state == S_IDLE)
	) else $error("dcache: request while an access is in flight");

endmodule

/* logic/victim_select.sv */
`timescale 1ns/1ns

module victim_select (
	input  logic                          clk,
	input  logic                          rst,
	input  cache_geometry_pkg::way_mask_t valid_bits,
	input  logic                          advance,
	output cache_geometry_pkg::way_mask_t victim
);

	localparam int WAYS = cache_geometry_pkg::NUM_WAYS;

	cache_geometry_pkg::way_mask_t ptr;

	// Rotating one-hot pointer, way 0 first
	always_ff @(posedge clk) begin
		if (rst) begin
			ptr <= cache_geometry_pkg::way_mask_t'(1);
		end else if (advance) begin
			ptr <= {ptr[WAYS-2:0], ptr[WAYS-1]};
		end
	end

	// Lowest free way wins, scanned from the top so it is assigned last
	always_comb begin
		victim = ptr;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (!valid_bits[w]) begin
				victim = '0;
				victim[w] = 1'b1;
			end
		end
	end

	// Pointer only moves on a fill into a full set
	advance_when_full_a: assert property (
		@(posedge clk) disable iff (rst)
		advance |-> &valid_bits
	) else $error("victim_select: pointer advanced while a way was free");

endmodule

/* logic/sp_ram.sv */
`timescale 1ns/1ns

module sp_ram #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = cache_geometry_pkg::NUM_SETS
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       en,
	input  logic                       we,
	input  cache_geometry_pkg::index_t addr,
	input  payload_t                   wdata,
	output payload_t                   rdata
);

	payload_t mem [DEPTH];

	// Clearing on reset leaves every tag invalid
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (en && we) begin
			mem[addr] <= wdata;
		end
	end

	// Read data one cycle after en, old contents on a write
	always_ff @(posedge clk) begin
		if (en) begin
			rdata <= mem[addr];
		end
	end

	addr_known_a: assert property (
		@(posedge clk) disable iff (rst)
		en |-> !$isunknown(addr)
	) else $error("sp_ram: unknown address with en high");

endmodule

/* logic/cache_bus_pkg.sv */
package cache_bus_pkg;

	// Core side
	typedef struct packed {
		logic [cache_geometry_pkg::ADDR_W-1:0] addr;
		logic write;
		logic [cache_geometry_pkg::WORD_W-1:0] wdata;
		logic [cache_geometry_pkg::WORD_W/8-1:0] strb;
	} cpu_req_t;

	// rdata holds the word after any store
	typedef struct packed {
		logic [cache_geometry_pkg::WORD_W-1:0] rdata;
		logic hit;
	} cpu_resp_t;

	// Memory side, always a full line
	typedef struct packed {
		logic [cache_geometry_pkg::LINE_ADDR_W-1:0] line_addr;
		logic write;
		cache_geometry_pkg::line_t line;
	} mem_req_t;

	typedef struct packed {
		cache_geometry_pkg::line_t line;
	} mem_resp_t;

endpackage

/* logic/cache_geometry_pkg.sv */
package cache_geometry_pkg;

	localparam int ADDR_W = 32;
	localparam int WORD_W = 64;
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 64;

	// A line holds two words
	localparam int LINE_BYTES = 2 * WORD_W / 8;
	localparam int OFFSET_W = $clog2(LINE_BYTES);
	localparam int INDEX_W = $clog2(NUM_SETS);
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
	localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;

	// Address bit that picks the word inside a line
	localparam int WORD_SEL = OFFSET_W - 1;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [NUM_WAYS-1:0] way_mask_t;

	// hi is the word at address bit 3 set
	typedef struct packed {
		logic [WORD_W-1:0] hi;
		logic [WORD_W-1:0] lo;
	} line_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

endpackage
